//--- verilog/layer_buf_pkg.sv
/*
 * Feature-map buffer shared types
 * Line width, command opcodes and the two views of a 128-bit line
 */
`default_nettype none

package layer_buf_pkg;

  localparam int LINE_W     = 128;
  localparam int PSUM_W     = 16;
  localparam int ACT_W      = 8;
  localparam int PSUM_LANES = LINE_W / PSUM_W;
  localparam int ACT_LANES  = LINE_W / ACT_W;

  // ======================================
  // Commands
  // ======================================
  typedef enum logic [1:0] {
    OP_WRITE     = 2'b00,
    OP_READ      = 2'b01,
    OP_READ_RELU = 2'b10,
    OP_ACC       = 2'b11
  } layer_op_e;

  // ======================================
  // Line views
  // ======================================
  typedef logic signed [PSUM_W-1:0] psum_t;
  typedef logic signed [ACT_W-1:0]  act_t;

  // Same 128 bits, partial sums for ACC or activations for ReLU reads
  typedef union packed {
    psum_t [PSUM_LANES-1:0] psum;
    act_t  [ACT_LANES-1:0]  act;
  } layer_line_u;

endpackage

`default_nettype wire

//--- verilog/layer_sram_wrapper.sv
/*
 * Dual-port line memory standing in for the compiled SRAM macro
 * Active-low write enables, output enables, write-first bypass between ports
 */
`timescale 1ns/1ps
`default_nettype none

module layer_sram_wrapper #(
  parameter int ADDR_W = 6
) (
  input  logic                             ck,
  input  logic                             oe_a,
  input  logic                             oe_b,
  input  logic                             we_a_n,
  input  logic                             we_b_n,
  input  logic [ADDR_W-1:0]                addr_a,
  input  logic [ADDR_W-1:0]                addr_b,
  input  logic [layer_buf_pkg::LINE_W-1:0] di_a,
  input  logic [layer_buf_pkg::LINE_W-1:0] di_b,
  output logic [layer_buf_pkg::LINE_W-1:0] do_a,
  output logic [layer_buf_pkg::LINE_W-1:0] do_b
);
  import layer_buf_pkg::*;

  localparam int DEPTH = 1 << ADDR_W;

  logic [LINE_W-1:0] mem [DEPTH];
  logic [LINE_W-1:0] rd_a_q;
  logic [LINE_W-1:0] rd_b_q;
  logic              hit_a;
  logic              hit_b;

  // Read word with write-first priority, other port before own port
  function automatic logic [LINE_W-1:0] pick_word(
    input logic              oth_hit,
    input logic [LINE_W-1:0] oth_di,
    input logic              own_wr,
    input logic [LINE_W-1:0] own_di,
    input logic [LINE_W-1:0] stored
  );
    if (oth_hit) begin
      return oth_di;
    end
    if (own_wr) begin
      return own_di;
    end
    return stored;
  endfunction

  assign hit_a = !we_b_n && (addr_b == addr_a);
  assign hit_b = !we_a_n && (addr_a == addr_b);

  // ======================================
  // Array and read registers
  // ======================================
  always_ff @(posedge ck) begin
    if (!we_a_n) begin
      mem[addr_a] <= di_a;
    end
    if (!we_b_n) begin
      mem[addr_b] <= di_b;
    end
  end

  // Output holds when its enable is low
  always_ff @(posedge ck) begin
    if (oe_a) begin
      rd_a_q <= pick_word(hit_a, di_b, !we_a_n, di_a, mem[addr_a]);
    end
    if (oe_b) begin
      rd_b_q <= pick_word(hit_b, di_a, !we_b_n, di_b, mem[addr_b]);
    end
  end

  assign do_a = rd_a_q;
  assign do_b = rd_b_q;

  a_no_dual_write : assert property (@(posedge ck)
    !(!we_a_n && !we_b_n && (addr_a == addr_b)));

endmodule

`default_nettype wire

//--- verilog/layer_cmd_decode.sv
/*
 * Command decode stage
 * Registers the command strobe and splits the opcode into stage controls
 */
`timescale 1ns/1ps
`default_nettype none

module layer_cmd_decode #(
  parameter int ADDR_W = 6
) (
  input  logic                       ck,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  layer_buf_pkg::layer_op_e   cmd_op,
  input  logic [ADDR_W-1:0]          cmd_addr,
  input  layer_buf_pkg::layer_line_u cmd_data,
  output logic                       dec_rd,
  output logic                       dec_wr,
  output logic                       dec_acc,
  output logic                       dec_relu,
  output logic [ADDR_W-1:0]          dec_addr,
  output layer_buf_pkg::layer_line_u dec_data
);
  import layer_buf_pkg::*;

  logic [3:0] ctl_next;

  // Order is rd, wr, acc, relu
  always_comb begin
    ctl_next = 4'b0000;
    if (cmd_valid) begin
      case (cmd_op)
        OP_WRITE:     ctl_next = 4'b0100;
        OP_READ:      ctl_next = 4'b1000;
        OP_READ_RELU: ctl_next = 4'b1001;
        OP_ACC:       ctl_next = 4'b1010;
        default:      ctl_next = 4'b0000;
      endcase
    end
  end

  always_ff @(posedge ck) begin
    if (!rst_n) begin
      {dec_rd, dec_wr, dec_acc, dec_relu} <= 4'b0000;
    end else begin
      {dec_rd, dec_wr, dec_acc, dec_relu} <= ctl_next;
    end
  end

  always_ff @(posedge ck) begin
    if (cmd_valid) begin
      dec_addr <= cmd_addr;
      dec_data <= cmd_data;
    end
  end

  // One command class per cycle at most
  a_ctl_onehot : assert property (@(posedge ck) disable iff (!rst_n)
    $onehot0({dec_wr, dec_rd && !dec_acc && !dec_relu, dec_acc, dec_relu}));

endmodule

`default_nettype wire

//--- verilog/layer_acc_execute.sv
/*
 * Execute stage
 * Issues the port A read, saturates partial sums and writes back on port B
 */
`timescale 1ns/1ps
`default_nettype none

module layer_acc_execute #(
  parameter int ADDR_W = 6
) (
  input  logic                       ck,
  input  logic                       rst_n,
  input  logic                       dec_rd,
  input  logic                       dec_wr,
  input  logic                       dec_acc,
  input  logic                       dec_relu,
  input  logic [ADDR_W-1:0]          dec_addr,
  input  layer_buf_pkg::layer_line_u dec_data,
  input  layer_buf_pkg::layer_line_u do_a,
  output logic                       oe_a,
  output logic [ADDR_W-1:0]          addr_a,
  output logic                       oe_b,
  output logic                       we_b_n,
  output logic [ADDR_W-1:0]          addr_b,
  output layer_buf_pkg::layer_line_u di_b,
  output logic                       rsp_pending,
  output logic                       rsp_relu
);
  import layer_buf_pkg::*;

  logic              s2_rd;
  logic              s2_wr;
  logic              s2_acc;
  logic              s2_relu;
  logic [ADDR_W-1:0] s2_addr;
  layer_line_u       s2_data;
  layer_line_u       acc_line;

  function automatic psum_t sat_add(input psum_t a, input psum_t b);
    logic [PSUM_W:0] sum;
    sum = {a[PSUM_W-1], a} + {b[PSUM_W-1], b};
    // Overflow when the two top bits disagree
    if (sum[PSUM_W] != sum[PSUM_W-1]) begin
      return sum[PSUM_W] ? psum_t'({1'b1, {(PSUM_W-1){1'b0}}})
                         : psum_t'({1'b0, {(PSUM_W-1){1'b1}}});
    end
    return psum_t'(sum[PSUM_W-1:0]);
  endfunction

  // ======================================
  // Stage 1
  // ======================================
  assign oe_a   = dec_rd;
  assign addr_a = dec_addr;

  always_ff @(posedge ck) begin
    if (!rst_n) begin
      s2_rd   <= 1'b0;
      s2_wr   <= 1'b0;
      s2_acc  <= 1'b0;
      s2_relu <= 1'b0;
    end else begin
      s2_rd   <= dec_rd;
      s2_wr   <= dec_wr;
      s2_acc  <= dec_acc;
      s2_relu <= dec_relu;
    end
  end

  always_ff @(posedge ck) begin
    s2_addr <= dec_addr;
    s2_data <= dec_data;
  end

  // ======================================
  // Stage 2
  // ======================================
  always_comb begin
    for (int i = 0; i < PSUM_LANES; i++) begin
      acc_line.psum[i] = sat_add(do_a.psum[i], s2_data.psum[i]);
    end
  end

  // Port B is write only
  assign oe_b   = 1'b0;
  assign we_b_n = !(s2_wr || s2_acc);
  assign addr_b = s2_addr;
  assign di_b   = s2_acc ? acc_line : s2_data;

  assign rsp_pending = s2_rd && !s2_acc;
  assign rsp_relu    = s2_relu;

  // Port B writes one op at a time and ACC follows its port A read
  a_wr_from_op : assert property (@(posedge ck) disable iff (!rst_n)
    !we_b_n |-> (s2_wr != s2_acc) && (s2_wr || $past(oe_a)));

endmodule

`default_nettype wire

//--- verilog/layer_read_result.sv
/*
 * Read response stage
 * Optional ReLU on the activation lanes, then the registered response
 */
`timescale 1ns/1ps
`default_nettype none

module layer_read_result (
  input  logic                       ck,
  input  logic                       rst_n,
  input  logic                       rsp_pending,
  input  logic                       rsp_relu,
  input  layer_buf_pkg::layer_line_u do_a,
  output logic                       rd_valid,
  output layer_buf_pkg::layer_line_u rd_data
);
  import layer_buf_pkg::*;

  layer_line_u relu_line;

  // Clamp negative activations
  always_comb begin
    relu_line = do_a;
    for (int i = 0; i < ACT_LANES; i++) begin
      if (rsp_relu && do_a.act[i][ACT_W-1]) begin
        relu_line.act[i] = '0;
      end
    end
  end

  always_ff @(posedge ck) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rsp_pending;
    end
  end

  always_ff @(posedge ck) begin
    if (rsp_pending) begin
      rd_data <= relu_line;
    end
  end

endmodule

`default_nettype wire

//--- verilog/layer_buf_top.sv
/*
 * Feature-map buffer for one CNN layer
 * Decode, execute and read response around the dual-port line memory
 */
`timescale 1ns/1ps
`default_nettype none

module layer_buf_top #(
  parameter int ADDR_W = 6
) (
  input  logic                       ck,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  layer_buf_pkg::layer_op_e   cmd_op,
  input  logic [ADDR_W-1:0]          cmd_addr,
  input  layer_buf_pkg::layer_line_u cmd_data,
  output logic                       rd_valid,
  output layer_buf_pkg::layer_line_u rd_data
);
  import layer_buf_pkg::*;

  logic              dec_rd;
  logic              dec_wr;
  logic              dec_acc;
  logic              dec_relu;
  logic [ADDR_W-1:0] dec_addr;
  layer_line_u       dec_data;
  logic              oe_a;
  logic              oe_b;
  logic              we_b_n;
  logic [ADDR_W-1:0] addr_a;
  logic [ADDR_W-1:0] addr_b;
  layer_line_u       di_b;
  layer_line_u       do_a;
  logic              rsp_pending;
  logic              rsp_relu;

  layer_cmd_decode #(
    .ADDR_W (ADDR_W)
  ) layer_cmd_decode_i (
    .ck        (ck),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .dec_rd    (dec_rd),
    .dec_wr    (dec_wr),
    .dec_acc   (dec_acc),
    .dec_relu  (dec_relu),
    .dec_addr  (dec_addr),
    .dec_data  (dec_data)
  );

  layer_acc_execute #(
    .ADDR_W (ADDR_W)
  ) layer_acc_execute_i (
    .ck          (ck),
    .rst_n       (rst_n),
    .dec_rd      (dec_rd),
    .dec_wr      (dec_wr),
    .dec_acc     (dec_acc),
    .dec_relu    (dec_relu),
    .dec_addr    (dec_addr),
    .dec_data    (dec_data),
    .do_a        (do_a),
    .oe_a        (oe_a),
    .addr_a      (addr_a),
    .oe_b        (oe_b),
    .we_b_n      (we_b_n),
    .addr_b      (addr_b),
    .di_b        (di_b),
    .rsp_pending (rsp_pending),
    .rsp_relu    (rsp_relu)
  );

  // Port A reads only, port B writes only with its OE held low
  layer_sram_wrapper #(
    .ADDR_W (ADDR_W)
  ) layer_sram_wrapper_i (
    .ck     (ck),
    .oe_a   (oe_a),
    .oe_b   (oe_b),
    .we_a_n (1'b1),
    .we_b_n (we_b_n),
    .addr_a (addr_a),
    .addr_b (addr_b),
    .di_a   ({LINE_W{1'b0}}),
    .di_b   (di_b),
    .do_a   (do_a),
    .do_b   ()
  );

  layer_read_result layer_read_result_i (
    .ck          (ck),
    .rst_n       (rst_n),
    .rsp_pending (rsp_pending),
    .rsp_relu    (rsp_relu),
    .do_a        (do_a),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data)
  );

endmodule

`default_nettype wire

//--- verif/layer_buf_tb.sv
/*
 * Testbench for the feature-map buffer
 * Seeded random commands checked against a line model and a response queue
 */
`timescale 1ns/1ps
`default_nettype none

module layer_buf_tb;
  import layer_buf_pkg::*;

  localparam int ADDR_W    = 6;
  localparam int DEPTH     = 1 << ADDR_W;
  localparam int CK_PERIOD = 8;
  localparam int RSP_LAT   = 3;

  logic              ck;
  logic              rst_n;
  logic              cmd_valid;
  layer_op_e         cmd_op;
  logic [ADDR_W-1:0] cmd_addr;
  layer_line_u       cmd_data;
  logic              rd_valid;
  layer_line_u       rd_data;

  layer_line_u model_mem [DEPTH];
  layer_line_u exp_line_q [$];
  bit          exp_relu_q [$];
  time         exp_time_q [$];
  string       exp_name_q [$];

  int    seed = 32'hddf9;
  int    err_cnt = 0;
  string test_name = "reset";

  layer_buf_top #(
    .ADDR_W (ADDR_W)
  ) layer_buf_top_i (
    .ck        (ck),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  initial begin
    ck = 1'b0;
    forever #(CK_PERIOD / 2) ck = ~ck;
  end

  // ========================================
  // Reference model
  // ========================================
  function automatic layer_line_u relu_model(input layer_line_u line);
    layer_line_u res;
    res = line;
    for (int i = 0; i < ACT_LANES; i++) begin
      if (line.act[i] < 0) begin
        res.act[i] = '0;
      end
    end
    return res;
  endfunction

  function automatic layer_line_u acc_model(input layer_line_u old_line,
                                            input layer_line_u add_line);
    layer_line_u res;
    int          sum;
    for (int i = 0; i < PSUM_LANES; i++) begin
      sum = int'(old_line.psum[i]) + int'(add_line.psum[i]);
      if (sum > 32767) begin
        sum = 32767;
      end else if (sum < -32768) begin
        sum = -32768;
      end
      res.psum[i] = psum_t'(sum);
    end
    return res;
  endfunction

  function automatic layer_line_u rand_line();
    logic [LINE_W-1:0] raw;
    for (int i = 0; i < LINE_W / 32; i++) begin
      raw[32*i +: 32] = $random(seed);
    end
    return layer_line_u'(raw);
  endfunction

  // Half the lanes near the 16-bit limits so sums saturate
  function automatic layer_line_u near_limit_line();
    layer_line_u res;
    int          v;
    for (int i = 0; i < PSUM_LANES; i++) begin
      case ($random(seed) & 3)
        0:       v = 32767 - ($random(seed) & 63);
        1:       v = -32768 + ($random(seed) & 63);
        default: v = $random(seed);
      endcase
      res.psum[i] = psum_t'(v);
    end
    return res;
  endfunction

  // ========================================
  // Compare tasks
  // ========================================
  task automatic raw_read_check(input string name, input layer_line_u exp,
                                input layer_line_u act);
    if (act !== exp) begin
      $display("FAILED %s read: expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic relu_read_check(input string name, input layer_line_u exp,
                                 input layer_line_u act);
    if (act !== exp) begin
      $display("FAILED %s relu read: expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic latency_check(input string name, input time exp_t, input time act_t);
    if (act_t != exp_t) begin
      $display("FAILED %s latency: expected %0t actual %0t", name, exp_t, act_t);
      err_cnt++;
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================
  task automatic send_cmd(input layer_op_e op, input logic [ADDR_W-1:0] addr,
                          input layer_line_u data);
    @(negedge ck);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = addr;
    cmd_data  = data;
    case (op)
      OP_WRITE: model_mem[addr] = data;
      OP_ACC:   model_mem[addr] = acc_model(model_mem[addr], data);
      default: begin
        if (op == OP_READ_RELU) begin
          exp_line_q.push_back(relu_model(model_mem[addr]));
        end else begin
          exp_line_q.push_back(model_mem[addr]);
        end
        exp_relu_q.push_back(op == OP_READ_RELU);
        exp_time_q.push_back($time + RSP_LAT * CK_PERIOD);
        exp_name_q.push_back(test_name);
      end
    endcase
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge ck);
      cmd_valid = 1'b0;
    end
  endtask

  // Responses sampled on the falling edge away from register updates
  always @(negedge ck) begin : rsp_monitor
    layer_line_u exp_line;
    string       name;
    if (rd_valid === 1'b1) begin
      if (exp_line_q.size() == 0) begin
        $display("ERROR: read response arrived with no read outstanding at %0t", $time);
        err_cnt++;
      end else begin
        exp_line = exp_line_q.pop_front();
        name     = exp_name_q.pop_front();
        if (exp_relu_q.pop_front()) begin
          relu_read_check(name, exp_line, rd_data);
        end else begin
          raw_read_check(name, exp_line, rd_data);
        end
        latency_check(name, exp_time_q.pop_front(), $time);
      end
    end
  end

  initial begin
    int                wait_cnt;
    layer_op_e         op;
    logic [ADDR_W-1:0] addr;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = OP_WRITE;
    cmd_addr  = '0;
    cmd_data  = '0;
    repeat (5) @(negedge ck);
    rst_n = 1'b1;

    test_name = "write_read_all";
    for (int a = 0; a < DEPTH; a++) begin
      send_cmd(OP_WRITE, a, rand_line());
    end
    for (int a = 0; a < DEPTH; a++) begin
      send_cmd(OP_READ, a, rand_line());
    end
    idle_cycles(4);

    test_name = "read_relu";
    for (int a = 0; a < DEPTH; a++) begin
      send_cmd(OP_READ_RELU, a, rand_line());
    end
    idle_cycles(4);

    test_name = "acc_saturate";
    repeat (3) begin
      for (int a = 0; a < DEPTH; a++) begin
        send_cmd(OP_ACC, a, near_limit_line());
      end
    end
    for (int a = 0; a < DEPTH; a++) begin
      send_cmd(OP_READ, a, rand_line());
    end
    idle_cycles(4);

    // Same address every cycle to hit the bypass
    test_name = "back_to_back";
    repeat (16) begin
      addr = $random(seed);
      send_cmd(OP_WRITE, addr, near_limit_line());
      send_cmd(OP_READ, addr, rand_line());
      send_cmd(OP_ACC, addr, near_limit_line());
      send_cmd(OP_ACC, addr, near_limit_line());
      send_cmd(OP_READ, addr, rand_line());
      send_cmd(OP_READ_RELU, addr, rand_line());
      send_cmd(OP_ACC, addr, near_limit_line());
      send_cmd(OP_WRITE, addr, rand_line());
      send_cmd(OP_READ_RELU, addr, rand_line());
    end
    idle_cycles(4);

    test_name = "random_mix";
    repeat (400) begin
      op   = layer_op_e'($random(seed) & 3);
      addr = $random(seed);
      if (op == OP_ACC && ($random(seed) & 1)) begin
        send_cmd(op, addr, near_limit_line());
      end else begin
        send_cmd(op, addr, rand_line());
      end
      if (($random(seed) & 3) == 0) begin
        idle_cycles(1 + ($random(seed) & 3));
      end
    end
    idle_cycles(1);

    wait_cnt = 0;
    while (exp_line_q.size() != 0 && wait_cnt < 16) begin
      @(negedge ck);
      wait_cnt++;
    end
    if (exp_line_q.size() != 0) begin
      $display("ERROR: timed out with %0d read responses outstanding", exp_line_q.size());
      err_cnt++;
    end
    idle_cycles(4);

    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
verilog/layer_buf_pkg.sv
verilog/layer_sram_wrapper.sv
verilog/layer_cmd_decode.sv
verilog/layer_acc_execute.sv
verilog/layer_read_result.sv
verilog/layer_buf_top.sv
verif/layer_buf_tb.sv
